//--- src/des_sbox.hex
efa72c4d
410dc1b2
d89e4a28
1ee31fe4
266079f6
fb36a20f
b3f9b68b
845a68d1
3911803a
a7d25dc9
62c83393
cd75f47e
5cbbde55
904c07a0
0524e56c
7a8f9b17
03ddead1
fd78bf0f
740b24bd
4795c278
ef36474a
224f7c93
d860d917
1ea315a4
ac2456ec
60870135
c152fd56
baecaecb
96c13020
59ba9bfe
3bfe8389
85196862
40da4917
1e662e4b
e7491fb4
8b90b5d1
da8ca2c9
64fbd83c
2d377c7e
b10d83e2
f5bff7a0
c81190f6
9c23c46a
76ce5a8d
3955610f
a3a23d53
52e80b95
0f74e628
fd13b462
c8af83b1
8ad0c2de
21067c87
436a1914
9f91e54a
148d2fa8
7278da7d
5b496b9f
b6f4fe5c
37e50109
ec3b97f0
a0bca6e3
05574025
6e225836
d9ce3dcb

//--- tb.f
src/des_pkg.sv
src/key_schedule.sv
src/des_round.sv
src/des_engine.sv
src/cfb_ctrl.sv
src/cfb_top.sv
testbench/clk_gen.sv
testbench/cfb_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cfb_top_tb -f tb.f -o cfb_sim
./obj_dir/cfb_sim | tee sim.log

if ! grep -qx "sim passed" sim.log; then
  exit 1
fi

//--- testbench/cfb_top_tb.sv
`timescale 1ns/10ps

module cfb_top_tb import des_pkg::*; ();

  localparam block_t KAT_KEY = 64'h1334_5779_9bbc_dff1;
  localparam block_t KAT_IV  = 64'h0123_4567_89ab_cdef;
  localparam int NUM_BYTES       = 32;
  localparam int REINIT_BYTES    = 5;
  localparam int CYCLES_PER_BYTE = 50;
  // Known answer, two passes each for round trip and error run, then re-init
  localparam int TOTAL_BYTES     = 2 + 4 * NUM_BYTES + REINIT_BYTES + 1;
  localparam int WATCHDOG_CYCLES = CYCLES_PER_BYTE * TOTAL_BYTES + 2000;

  logic   CLK;
  logic   RST;
  block_t key;
  block_t iv;
  logic   init;
  logic   decrypt;
  logic   req;
  byte_t  data_in;
  logic   ack;
  byte_t  data_out;

  integer seed;
  int     pass_count;
  int     fail_count;
  int     handshake_fails;
  byte_t  plain [NUM_BYTES];
  byte_t  cipher [NUM_BYTES];
  byte_t  result;

  clk_gen i_clk_gen (
    .CLK (CLK),
    .RST (RST)
  );

  cfb_top i_cfb_top (
    .CLK      (CLK),
    .RST      (RST),
    .key      (key),
    .iv       (iv),
    .init     (init),
    .decrypt  (decrypt),
    .req      (req),
    .data_in  (data_in),
    .ack      (ack),
    .data_out (data_out)
  );

  reset_ack: assert property (@(posedge CLK) !RST |-> !ack)
    else begin
      handshake_fails++;
      $display("error at %0t: ack is high during reset", $time);
    end

  // ack may rise only in answer to a request seen on the previous edge
  ack_rise: assert property (@(posedge CLK) disable iff (!RST) $rose(ack) |-> $past(req))
    else begin
      handshake_fails++;
      $display("error at %0t: ack rose while req was low", $time);
    end

  ack_fall: assert property (@(posedge CLK) disable iff (!RST) $fell(ack) |-> !$past(req))
    else begin
      handshake_fails++;
      $display("error at %0t: ack fell before req was released", $time);
    end

  out_hold: assert property (@(posedge CLK) disable iff (!RST)
                             ack && $past(ack) |-> $stable(data_out))
    else begin
      handshake_fails++;
      $display("error at %0t: data_out changed while ack was high", $time);
    end

  task automatic check_value(input string name, input int idx, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("error at %0t: %s (byte %0d) expected %h, got %h",
               $time, name, idx, expected, actual);
    end
  endtask

  task automatic load_key(input block_t new_key, input block_t new_iv);
    @(negedge CLK);
    key  = new_key;
    iv   = new_iv;
    init = 1'b1;
    @(negedge CLK);
    init = 1'b0;
  endtask

  task automatic transfer_byte(input byte_t din, input logic dec, output byte_t dout);
    int hold;
    @(negedge CLK);
    data_in = din;
    decrypt = dec;
    req     = 1'b1;
    while (!ack) begin
      @(negedge CLK);
    end
    dout = data_out;
    // Extra cycles with req held exercise back-pressure
    hold = {$random(seed)} % 4;
    repeat (hold) @(negedge CLK);
    req = 1'b0;
    while (ack) begin
      @(negedge CLK);
    end
  endtask

  task automatic encrypt_random(input block_t new_key, input block_t new_iv);
    load_key(new_key, new_iv);
    for (int i = 0; i < NUM_BYTES; i++) begin
      plain[i] = byte_t'($random(seed));
      transfer_byte(plain[i], 1'b0, cipher[i]);
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failing checks", name, fail_count - fails_before);
    end
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin : stimulus
    int     fails_before;
    int     flip_pos;
    byte_t  flip_mask;
    byte_t  in_byte;
    block_t rand_key;
    block_t rand_iv;
    seed            = 32'h4d7c82ca;
    pass_count      = 0;
    fail_count      = 0;
    handshake_fails = 0;
    key             = '0;
    iv              = '0;
    init            = 1'b0;
    decrypt         = 1'b0;
    req             = 1'b0;
    data_in         = '0;
    @(posedge RST);
    @(negedge CLK);

    fails_before = fail_count;
    check_value("ack", 0, 8'h00, {7'b0, ack});
    check_value("data_out", 0, 8'h00, data_out);
    report_test("reset", fails_before);

    // First byte of the textbook DES block 85E813540F0AB405
    fails_before = fail_count;
    load_key(KAT_KEY, KAT_IV);
    transfer_byte(8'h00, 1'b0, result);
    check_value("data_out", 0, 8'h85, result);
    load_key(KAT_KEY, KAT_IV);
    transfer_byte(8'h12, 1'b1, result);
    check_value("data_out", 1, 8'h97, result);
    report_test("known_answer", fails_before);

    fails_before = fail_count;
    rand_key = {$random(seed), $random(seed)};
    rand_iv  = {$random(seed), $random(seed)};
    encrypt_random(rand_key, rand_iv);
    load_key(rand_key, rand_iv);
    for (int i = 0; i < NUM_BYTES; i++) begin
      transfer_byte(cipher[i], 1'b1, result);
      check_value("data_out", i, plain[i], result);
    end
    report_test("round_trip", fails_before);

    fails_before = fail_count;
    rand_key  = {$random(seed), $random(seed)};
    rand_iv   = {$random(seed), $random(seed)};
    flip_pos  = 4 + {$random(seed)} % 8;
    flip_mask = byte_t'(8'h01 << ({$random(seed)} % 8));
    encrypt_random(rand_key, rand_iv);
    load_key(rand_key, rand_iv);
    for (int i = 0; i < NUM_BYTES; i++) begin
      in_byte = (i == flip_pos) ? cipher[i] ^ flip_mask : cipher[i];
      transfer_byte(in_byte, 1'b1, result);
      if (i == flip_pos) begin
        check_value("data_out", i, plain[i] ^ flip_mask, result);
      end else if (i < flip_pos || i > flip_pos + 8) begin
        // The bad byte garbles output while it sits in the 8-byte register
        check_value("data_out", i, plain[i], result);
      end
    end
    report_test("error_propagation", fails_before);

    fails_before = fail_count;
    load_key({$random(seed), $random(seed)}, {$random(seed), $random(seed)});
    for (int i = 0; i < REINIT_BYTES; i++) begin
      transfer_byte(byte_t'($random(seed)), 1'b0, result);
    end
    load_key(KAT_KEY, KAT_IV);
    transfer_byte(8'h00, 1'b0, result);
    check_value("data_out", 0, 8'h85, result);
    report_test("re_init", fails_before);

    if (handshake_fails == 0) begin
      $display("test handshake: ok");
    end else begin
      $display("test handshake: %0d rule violations", handshake_fails);
    end
    $display("passed checks: %0d, failed checks: %0d",
             pass_count, fail_count + handshake_fails);
    if (fail_count + handshake_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- testbench/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
  output logic CLK,
  output logic RST
);

  // 20 ns period
  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Reset covers four full cycles and is released on a falling edge
  initial begin
    RST = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
  end

endmodule

//--- src/cfb_top.sv
`timescale 1ns/10ps

module cfb_top import des_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  block_t key,
  input  block_t iv,
  input  logic   init,
  input  logic   decrypt,
  input  logic   req,
  input  byte_t  data_in,
  output logic   ack,
  output byte_t  data_out
);

  logic    key_ready;
  logic    start;
  logic    done;
  block_t  block_in;
  block_t  block_out;
  round_t  round_idx;
  subkey_t subkey;

  cfb_ctrl i_cfb_ctrl (
    .CLK       (CLK),
    .RST       (RST),
    .iv        (iv),
    .init      (init),
    .decrypt   (decrypt),
    .req       (req),
    .data_in   (data_in),
    .ack       (ack),
    .data_out  (data_out),
    .key_ready (key_ready),
    .start     (start),
    .block_in  (block_in),
    .done      (done),
    .block_out (block_out)
  );

  key_schedule i_key_schedule (
    .CLK       (CLK),
    .RST       (RST),
    .key       (key),
    .init      (init),
    .key_ready (key_ready),
    .round_idx (round_idx),
    .subkey    (subkey)
  );

  des_engine i_des_engine (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .block_in  (block_in),
    .done      (done),
    .block_out (block_out),
    .round_idx (round_idx),
    .subkey    (subkey)
  );

endmodule

//--- src/cfb_ctrl.sv
`timescale 1ns/10ps

module cfb_ctrl import des_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  block_t iv,
  input  logic   init,
  input  logic   decrypt,
  input  logic   req,
  input  byte_t  data_in,
  output logic   ack,
  output byte_t  data_out,
  input  logic   key_ready,
  output logic   start,
  output block_t block_in,
  input  logic   done,
  input  block_t block_out
);

  typedef enum logic [2:0] {IDLE, WAIT_KEY, RUN, ACK, RELEASE} state_t;

  state_t state;
  block_t fb_reg;
  byte_t  din_q;
  logic   dec_q;
  byte_t  result;
  byte_t  fb_byte;

  // Leftmost keystream byte mixed with the captured input
  assign result = block_out[0:7] ^ din_q;

  // The ciphertext byte is always the one fed back
  assign fb_byte  = dec_q ? din_q : result;
  assign block_in = fb_reg;

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      state    <= IDLE;
      ack      <= 1'b0;
      start    <= 1'b0;
      data_out <= '0;
      fb_reg   <= '0;
    end else if (init) begin
      state  <= IDLE;
      ack    <= 1'b0;
      start  <= 1'b0;
      fb_reg <= iv;
    end else begin
      start <= 1'b0;
      case (state)
        IDLE: begin
          if (req) begin
            if (key_ready) begin
              start <= 1'b1;
              state <= RUN;
            end else begin
              state <= WAIT_KEY;
            end
          end
        end
        WAIT_KEY: begin
          if (key_ready) begin
            start <= 1'b1;
            state <= RUN;
          end
        end
        RUN: begin
          if (done) begin
            data_out <= result;
            fb_reg   <= {fb_reg[8:63], fb_byte};
            ack      <= 1'b1;
            state    <= ACK;
          end
        end
        ACK: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= RELEASE;
          end
        end
        RELEASE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && req) begin
      din_q <= data_in;
      dec_q <= decrypt;
    end
  end

endmodule

//--- src/des_engine.sv
`timescale 1ns/10ps

module des_engine import des_pkg::*; (
  input  logic    CLK,
  input  logic    RST,
  input  logic    start,
  input  block_t  block_in,
  output logic    done,
  output block_t  block_out,
  output round_t  round_idx,
  input  subkey_t subkey
);

  typedef enum logic {IDLE, ROUNDS} state_t;

  state_t state;
  half_t  left;
  half_t  right;
  half_t  left_next;
  half_t  right_next;
  block_t ip_block;

  des_round i_des_round (
    .left       (left),
    .right      (right),
    .subkey     (subkey),
    .left_next  (left_next),
    .right_next (right_next)
  );

  always_comb begin
    for (int i = 0; i < 64; i++) begin
      ip_block[i] = block_in[IP_TABLE[i]];
    end
  end

  // Halves are swapped back before the final permutation
  always_comb begin
    block_t preout;
    preout = {right, left};
    for (int i = 0; i < 64; i++) begin
      block_out[i] = preout[FP_TABLE[i]];
    end
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      state     <= IDLE;
      round_idx <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            round_idx <= '0;
            state     <= ROUNDS;
          end
        end
        ROUNDS: begin
          round_idx <= round_idx + 1'b1;
          if (round_idx == round_t'(NUM_ROUNDS - 1)) begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      left  <= ip_block[0:31];
      right <= ip_block[32:63];
    end else if (state == ROUNDS) begin
      left  <= left_next;
      right <= right_next;
    end
  end

endmodule

//--- src/des_round.sv
`timescale 1ns/10ps

module des_round import des_pkg::*; (
  input  half_t   left,
  input  half_t   right,
  input  subkey_t subkey,
  output half_t   left_next,
  output half_t   right_next
);

  // Each word carries one nibble per box, box 0 in the leftmost nibble
  logic [0:31] sbox [64];

  subkey_t mixed;
  half_t   sbox_out;
  half_t   f_out;

  initial begin
    $readmemh(SBOX_FILE, sbox);
  end

  always_comb begin
    subkey_t     expanded;
    logic [0:5]  chunk;
    logic [5:0]  addr;
    for (int i = 0; i < 48; i++) begin
      expanded[i] = right[E_TABLE[i]];
    end
    mixed = expanded ^ subkey;
    for (int b = 0; b < 8; b++) begin
      chunk = mixed[6*b +: 6];
      // Outer bits pick the row, inner bits the column
      addr = {chunk[0], chunk[5], chunk[1:4]};
      sbox_out[4*b +: 4] = sbox[addr][4*b +: 4];
    end
    for (int i = 0; i < 32; i++) begin
      f_out[i] = sbox_out[P_TABLE[i]];
    end
  end

  assign left_next  = right;
  assign right_next = left ^ f_out;

endmodule

//--- src/key_schedule.sv
`timescale 1ns/10ps

module key_schedule import des_pkg::*; (
  input  logic    CLK,
  input  logic    RST,
  input  block_t  key,
  input  logic    init,
  output logic    key_ready,
  input  round_t  round_idx,
  output subkey_t subkey
);

  logic [0:55] pc1_out;
  logic [0:27] c_half;
  logic [0:27] d_half;
  logic [0:27] c_rot;
  logic [0:27] d_rot;
  logic [0:55] cd_rot;
  subkey_t     pc2_out;
  subkey_t     round_keys [NUM_ROUNDS];
  round_t      cnt;
  logic        busy;

  always_comb begin
    for (int i = 0; i < 56; i++) begin
      pc1_out[i] = key[PC1_TABLE[i]];
    end
  end

  // Rotation amount for the key that is stored this cycle
  always_comb begin
    if (SHIFT_TABLE[cnt] == 1) begin
      c_rot = {c_half[1:27], c_half[0]};
      d_rot = {d_half[1:27], d_half[0]};
    end else begin
      c_rot = {c_half[2:27], c_half[0:1]};
      d_rot = {d_half[2:27], d_half[0:1]};
    end
    cd_rot = {c_rot, d_rot};
    for (int i = 0; i < 48; i++) begin
      pc2_out[i] = cd_rot[PC2_TABLE[i]];
    end
  end

  always_ff @(posedge CLK or negedge RST) begin
    if (!RST) begin
      busy      <= 1'b0;
      cnt       <= '0;
      key_ready <= 1'b0;
    end else if (init) begin
      busy      <= 1'b1;
      cnt       <= '0;
      key_ready <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == round_t'(NUM_ROUNDS - 1)) begin
        busy      <= 1'b0;
        key_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (init) begin
      c_half <= pc1_out[0:27];
      d_half <= pc1_out[28:55];
    end else if (busy) begin
      c_half          <= c_rot;
      d_half          <= d_rot;
      round_keys[cnt] <= pc2_out;
    end
  end

  assign subkey = round_keys[round_idx];

endmodule

//--- src/des_pkg.sv
package des_pkg;

  // Bit 0 is the leftmost bit throughout, as in the DES standard
  typedef logic [0:63] block_t;
  typedef logic [0:31] half_t;
  typedef logic [0:47] subkey_t;
  typedef logic [0:7]  byte_t;
  typedef logic [3:0]  round_t;

  localparam int NUM_ROUNDS = 16;

  localparam string SBOX_FILE = "src/des_sbox.hex";

  // Tables hold zero-based source bit positions
  localparam int IP_TABLE [64] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
    61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7,
    56, 48, 40, 32, 24, 16,  8,  0, 58, 50, 42, 34, 26, 18, 10,  2,
    60, 52, 44, 36, 28, 20, 12,  4, 62, 54, 46, 38, 30, 22, 14,  6
  };

  localparam int FP_TABLE [64] = '{
    39,  7, 47, 15, 55, 23, 63, 31, 38,  6, 46, 14, 54, 22, 62, 30,
    37,  5, 45, 13, 53, 21, 61, 29, 36,  4, 44, 12, 52, 20, 60, 28,
    35,  3, 43, 11, 51, 19, 59, 27, 34,  2, 42, 10, 50, 18, 58, 26,
    33,  1, 41,  9, 49, 17, 57, 25, 32,  0, 40,  8, 48, 16, 56, 24
  };

  localparam int E_TABLE [48] = '{
    31,  0,  1,  2,  3,  4,  3,  4,  5,  6,  7,  8,  7,  8,  9, 10,
    11, 12, 11, 12, 13, 14, 15, 16, 15, 16, 17, 18, 19, 20, 19, 20,
    21, 22, 23, 24, 23, 24, 25, 26, 27, 28, 27, 28, 29, 30, 31,  0
  };

  localparam int P_TABLE [32] = '{
    15,  6, 19, 20, 28, 11, 27, 16,  0, 14, 22, 25,  4, 17, 30,  9,
     1,  7, 23, 13, 31, 26,  2,  8, 18, 12, 29,  5, 21, 10,  3, 24
  };

  // First 28 entries build the C half and the rest build the D half
  localparam int PC1_TABLE [56] = '{
    56, 48, 40, 32, 24, 16,  8,  0, 57, 49, 41, 33, 25, 17,
     9,  1, 58, 50, 42, 34, 26, 18, 10,  2, 59, 51, 43, 35,
    62, 54, 46, 38, 30, 22, 14,  6, 61, 53, 45, 37, 29, 21,
    13,  5, 60, 52, 44, 36, 28, 20, 12,  4, 27, 19, 11,  3
  };

  localparam int PC2_TABLE [48] = '{
    13, 16, 10, 23,  0,  4,  2, 27, 14,  5, 20,  9, 22, 18, 11,  3,
    25,  7, 15,  6, 26, 19, 12,  1, 40, 51, 30, 36, 46, 54, 29, 39,
    50, 44, 32, 47, 43, 48, 38, 55, 33, 52, 45, 41, 49, 35, 28, 31
  };

  localparam int SHIFT_TABLE [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

endpackage
